// File: project.f
redmule_pkg.sv
redmule_sched_if.sv
redmule_stream_fifo.sv
redmule_engine.sv
redmule_z_buffer.sv
redmule_scheduler.sv
redmule_ctrl.sv
redmule_top.sv
redmule_props.sv
tb_redmule.sv

// File: redmule_ctrl.sv
// Register file with trigger, K steps and status, plus busy flag and end-of-job event
`timescale 1ns/1ns

module redmule_ctrl
  import redmule_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  periph_req_i,
  input  logic                  periph_we_i,
  input  logic [REG_ADDR_W-1:0] periph_addr_i,
  input  logic [REG_DATA_W-1:0] periph_wdata_i,
  output logic                  periph_gnt_o,
  output logic [REG_DATA_W-1:0] periph_rdata_o,
  output logic                  periph_rvalid_o,
  redmule_sched_if.controller   sched,
  output logic                  busy_o,
  output logic                  evt_o
);

  steps_t                  k_q;
  logic                    busy_q, start_q, evt_q, rvalid_q;
  logic [REG_DATA_W-1:0]   rdata_q;
  logic                    wr_en, rd_en, trigger;

  // Always granted in the request cycle
  assign periph_gnt_o = periph_req_i;
  assign wr_en        = periph_req_i && periph_we_i;
  assign rd_en        = periph_req_i && !periph_we_i;
  // Trigger while busy is dropped
  assign trigger      = wr_en && (periph_addr_i == REG_TRIGGER) && !busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      k_q      <= '0;
      busy_q   <= 1'b0;
      start_q  <= 1'b0;
      evt_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_en && (periph_addr_i == REG_K_STEPS)) k_q <= periph_wdata_i[STEP_W-1:0];
      if (trigger) begin
        busy_q <= 1'b1;
      end else if (sched.done) begin
        busy_q <= 1'b0;
      end
      start_q  <= trigger;
      evt_q    <= sched.done;
      rvalid_q <= rd_en;
    end
  end

  // Read data for the response one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (periph_addr_i)
        REG_K_STEPS: rdata_q <= REG_DATA_W'(k_q);
        REG_STATUS:  rdata_q <= REG_DATA_W'(busy_q);
        default:     rdata_q <= '0;
      endcase
    end
  end

  assign sched.start     = start_q;
  assign sched.k_steps   = k_q;
  assign busy_o          = busy_q;
  assign evt_o           = evt_q;
  assign periph_rdata_o  = rdata_q;
  assign periph_rvalid_o = rvalid_q;

endmodule

// File: redmule_engine.sv
// Two-stage pipelined multiply-accumulate array with bias load
`timescale 1ns/1ns

module redmule_engine
  import redmule_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  x_col_t x_col_i,
  input  row_t   w_row_i,
  input  tile_t  y_bias_i,
  input  logic   bias_load_i,
  input  logic   step_valid_i,
  output tile_t  acc_o
);

  // Stage one holds the outer product of one step
  tile_t prod_q;
  logic  prod_valid_q;
  // Stage two holds the running sums
  tile_t acc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prod_valid_q <= 1'b0;
    end else begin
      prod_valid_q <= step_valid_i;
    end
  end

  // Lower ELEM_W bits of each product, identical for signed and unsigned
  always_ff @(posedge clk_i) begin
    if (step_valid_i) begin
      for (int r = 0; r < ARRAY_WIDTH; r++) begin
        for (int c = 0; c < ARRAY_HEIGHT; c++) begin
          prod_q[r][c] <= x_col_i[r] * w_row_i[c];
        end
      end
    end
  end

  // Bias load overwrites the tile, otherwise accumulate with wrap
  always_ff @(posedge clk_i) begin
    if (bias_load_i) begin
      acc_q <= y_bias_i;
    end else if (prod_valid_q) begin
      for (int r = 0; r < ARRAY_WIDTH; r++) begin
        for (int c = 0; c < ARRAY_HEIGHT; c++) begin
          acc_q[r][c] <= acc_q[r][c] + prod_q[r][c];
        end
      end
    end
  end

  assign acc_o = acc_q;

endmodule

// File: redmule_pkg.sv
// Array sizes, element, row and tile types, register map and scheduler states
package redmule_pkg;

  // Array geometry and arithmetic
  localparam int unsigned ARRAY_WIDTH  = 4;
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned ELEM_W       = 16;
  localparam int unsigned STEP_W       = 8;
  localparam int unsigned ENGINE_LAT   = 2;

  // Register port
  localparam int unsigned REG_ADDR_W = 2;
  localparam int unsigned REG_DATA_W = 32;

  localparam logic [REG_ADDR_W-1:0] REG_TRIGGER = REG_ADDR_W'(0);
  localparam logic [REG_ADDR_W-1:0] REG_K_STEPS = REG_ADDR_W'(1);
  localparam logic [REG_ADDR_W-1:0] REG_STATUS  = REG_ADDR_W'(2);

  // One signed element, wraps on overflow
  typedef logic signed [ELEM_W-1:0] elem_t;

  // One column of X, one element per array row
  typedef elem_t [ARRAY_WIDTH-1:0] x_col_t;

  // One row of W, Y or Z
  typedef elem_t [ARRAY_HEIGHT-1:0] row_t;

  // Full accumulator tile, row 0 at index 0
  typedef row_t [ARRAY_WIDTH-1:0] tile_t;

  typedef logic [STEP_W-1:0] steps_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_Y,
    BIAS,
    COMPUTE,
    DRAIN,
    CAPTURE,
    STORE
  } sched_state_e;

endpackage

// File: redmule_props.sv
// Bound assertions on the Z stream hold rule, the end-of-job event and reset values
`timescale 1ns/1ns

module redmule_props
  import redmule_pkg::*;
(
  input logic clk_i,
  input logic rst_n_i,
  input logic z_valid_o,
  input row_t z_data_o,
  input logic z_ready_i,
  input logic busy_o,
  input logic evt_o
);

  // A stalled Z beat keeps its valid and data
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (z_valid_o && !z_ready_i) |=> (z_valid_o && $stable(z_data_o)))
    else $error("Z beat changed while stalled");

  // Event is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_n_i) evt_o |=> !evt_o)
    else $error("evt_o high for two cycles");

  // First cycle out of reset
  assert property (@(posedge clk_i) $rose(rst_n_i) |-> (!busy_o && !evt_o))
    else $error("busy_o or evt_o high after reset");

endmodule

bind redmule_top redmule_props props0 (.*);

// File: redmule_sched_if.sv
// Controller to scheduler handshake with controller and scheduler modports
`timescale 1ns/1ns

interface redmule_sched_if import redmule_pkg::*; ();

  // One-cycle job start from the register file
  logic   start;
  steps_t k_steps;
  // One-cycle pulse when the last Z row is accepted
  logic   done;

  modport controller (
    output start,
    output k_steps,
    input  done
  );

  modport scheduler (
    input  start,
    input  k_steps,
    output done
  );

endinterface

// File: redmule_scheduler.sv
// Job phase FSM with step, row and drain counters driving FIFO, engine and buffer strobes
`timescale 1ns/1ns

module redmule_scheduler
  import redmule_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  redmule_sched_if.scheduler        sched,
  input  logic                      x_valid_i,
  input  logic                      w_valid_i,
  input  logic                      y_valid_i,
  input  logic                      z_ready_i,
  input  logic                      last_row_i,
  output logic                      x_pop_o,
  output logic                      w_pop_o,
  output logic                      y_pop_o,
  output logic                      y_push_o,
  output logic                      bias_load_o,
  output logic                      step_valid_o,
  output logic                      capture_o,
  output logic                      z_store_o,
  output logic                      z_push_o
);

  sched_state_e                   state_q;
  steps_t                         step_cnt_q;
  logic [$clog2(ARRAY_WIDTH)-1:0] row_cnt_q;
  logic [$clog2(ENGINE_LAT)-1:0]  drain_cnt_q;
  logic                           step_fire;

  // A step needs one X column and one W row at the same time
  assign step_fire = (state_q == COMPUTE) && x_valid_i && w_valid_i;

  always_comb begin
    y_pop_o      = (state_q == LOAD_Y) && y_valid_i;
    y_push_o     = y_pop_o;
    bias_load_o  = (state_q == BIAS);
    x_pop_o      = step_fire;
    w_pop_o      = step_fire;
    step_valid_o = step_fire;
    capture_o    = (state_q == CAPTURE);
    z_push_o     = (state_q == STORE);
    z_store_o    = z_push_o && z_ready_i;
  end

  assign sched.done = z_store_o && last_row_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      step_cnt_q  <= '0;
      row_cnt_q   <= '0;
      drain_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (sched.start) begin
            // K is latched here, later register writes do not affect the job
            step_cnt_q <= sched.k_steps;
            row_cnt_q  <= '0;
            state_q    <= LOAD_Y;
          end
        end
        LOAD_Y: begin
          if (y_valid_i) begin
            row_cnt_q <= row_cnt_q + 1'b1;
            if (row_cnt_q == ARRAY_WIDTH-1) state_q <= BIAS;
          end
        end
        // Nothing to accumulate when K is 0
        BIAS: state_q <= (step_cnt_q == '0) ? CAPTURE : COMPUTE;
        COMPUTE: begin
          if (step_fire) begin
            step_cnt_q <= step_cnt_q - 1'b1;
            if (step_cnt_q == steps_t'(1)) begin
              drain_cnt_q <= '0;
              state_q     <= DRAIN;
            end
          end
        end
        DRAIN: begin
          drain_cnt_q <= drain_cnt_q + 1'b1;
          if (drain_cnt_q == ENGINE_LAT-1) state_q <= CAPTURE;
        end
        CAPTURE: state_q <= STORE;
        STORE: begin
          if (sched.done) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: redmule_stream_fifo.sv
// Valid/ready circular FIFO with a type parameter for the payload
`timescale 1ns/1ns

module redmule_stream_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic clear_i,
  input  logic push_valid_i,
  input  T     push_data_i,
  output logic push_ready_o,
  output logic pop_valid_o,
  output T     pop_data_o,
  input  logic pop_ready_i
);

  T                             mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wptr_q, rptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic                         push_fire, pop_fire;

  // Ready while not full, so back-pressure reaches the producer
  assign push_ready_o = (count_q != DEPTH);
  assign pop_valid_o  = (count_q != 0);
  assign pop_data_o   = mem_q[rptr_q];

  assign push_fire = push_valid_i && push_ready_o;
  assign pop_fire  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (clear_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_fire) begin
        wptr_q <= (wptr_q == DEPTH-1) ? '0 : wptr_q + 1'b1;
      end
      if (pop_fire) begin
        rptr_q <= (rptr_q == DEPTH-1) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: redmule_top.sv
// Accelerator top level connecting stream FIFOs, controller, scheduler, z buffer and engine
`timescale 1ns/1ns

module redmule_top
  import redmule_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Register port
  input  logic                  periph_req_i,
  input  logic                  periph_we_i,
  input  logic [REG_ADDR_W-1:0] periph_addr_i,
  input  logic [REG_DATA_W-1:0] periph_wdata_i,
  output logic                  periph_gnt_o,
  output logic [REG_DATA_W-1:0] periph_rdata_o,
  output logic                  periph_rvalid_o,
  // Input streams
  input  logic                  x_valid_i,
  input  x_col_t                x_data_i,
  output logic                  x_ready_o,
  input  logic                  w_valid_i,
  input  row_t                  w_data_i,
  output logic                  w_ready_o,
  input  logic                  y_valid_i,
  input  row_t                  y_data_i,
  output logic                  y_ready_o,
  // Result stream
  output logic                  z_valid_o,
  output row_t                  z_data_o,
  input  logic                  z_ready_i,
  output logic                  busy_o,
  output logic                  evt_o
);

  x_col_t x_col;
  row_t   w_row, y_row, z_row;
  tile_t  y_bias, acc;
  logic   x_fifo_valid, w_fifo_valid, y_fifo_valid, z_fifo_ready;
  logic   x_pop, w_pop, y_pop, y_push, bias_load, step_valid;
  logic   capture, z_store, z_push, last_row;

  redmule_sched_if sched ();

  redmule_ctrl i_ctrl (
    .clk_i, .rst_n_i, .periph_req_i, .periph_we_i, .periph_addr_i, .periph_wdata_i,
    .periph_gnt_o, .periph_rdata_o, .periph_rvalid_o,
    .sched   ( sched.controller ),
    .busy_o, .evt_o
  );

  redmule_scheduler i_scheduler (
    .clk_i, .rst_n_i,
    .sched        ( sched.scheduler ),
    .x_valid_i    ( x_fifo_valid    ),
    .w_valid_i    ( w_fifo_valid    ),
    .y_valid_i    ( y_fifo_valid    ),
    .z_ready_i    ( z_fifo_ready    ),
    .last_row_i   ( last_row        ),
    .x_pop_o      ( x_pop           ),
    .w_pop_o      ( w_pop           ),
    .y_pop_o      ( y_pop           ),
    .y_push_o     ( y_push          ),
    .bias_load_o  ( bias_load       ),
    .step_valid_o ( step_valid      ),
    .capture_o    ( capture         ),
    .z_store_o    ( z_store         ),
    .z_push_o     ( z_push          )
  );

  // Input FIFOs never clear, beats may arrive before the trigger
  redmule_stream_fifo #(.T(x_col_t), .DEPTH(4)) i_x_fifo (
    .clk_i, .rst_n_i, .clear_i(1'b0),
    .push_valid_i(x_valid_i), .push_data_i(x_data_i), .push_ready_o(x_ready_o),
    .pop_valid_o(x_fifo_valid), .pop_data_o(x_col), .pop_ready_i(x_pop)
  );

  redmule_stream_fifo #(.T(row_t), .DEPTH(4)) i_w_fifo (
    .clk_i, .rst_n_i, .clear_i(1'b0),
    .push_valid_i(w_valid_i), .push_data_i(w_data_i), .push_ready_o(w_ready_o),
    .pop_valid_o(w_fifo_valid), .pop_data_o(w_row), .pop_ready_i(w_pop)
  );

  redmule_stream_fifo #(.T(row_t), .DEPTH(4)) i_y_fifo (
    .clk_i, .rst_n_i, .clear_i(1'b0),
    .push_valid_i(y_valid_i), .push_data_i(y_data_i), .push_ready_o(y_ready_o),
    .pop_valid_o(y_fifo_valid), .pop_data_o(y_row), .pop_ready_i(y_pop)
  );

  redmule_stream_fifo #(.T(row_t), .DEPTH(2)) i_z_fifo (
    .clk_i, .rst_n_i, .clear_i(1'b0),
    .push_valid_i(z_push), .push_data_i(z_row), .push_ready_o(z_fifo_ready),
    .pop_valid_o(z_valid_o), .pop_data_o(z_data_o), .pop_ready_i(z_ready_i)
  );

  redmule_z_buffer i_z_buffer (
    .clk_i, .rst_n_i,
    .y_push_i(y_push), .y_row_i(y_row), .capture_i(capture), .acc_i(acc),
    .store_i(z_store), .y_bias_o(y_bias), .z_row_o(z_row), .last_row_o(last_row)
  );

  redmule_engine i_engine (
    .clk_i, .rst_n_i,
    .x_col_i(x_col), .w_row_i(w_row), .y_bias_i(y_bias),
    .bias_load_i(bias_load), .step_valid_i(step_valid), .acc_o(acc)
  );

endmodule

// File: redmule_z_buffer.sv
// Row buffer that loads the Y bias rows and stores the result tile row by row
`timescale 1ns/1ns

module redmule_z_buffer
  import redmule_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  y_push_i,
  input  row_t  y_row_i,
  input  logic  capture_i,
  input  tile_t acc_i,
  input  logic  store_i,
  output tile_t y_bias_o,
  output row_t  z_row_o,
  output logic  last_row_o
);

  tile_t                          rows_q;
  logic [$clog2(ARRAY_WIDTH)-1:0] row_ptr_q;

  // Incoming Y rows shift down, so the first row ends at index 0
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      rows_q <= acc_i;
    end else if (y_push_i) begin
      rows_q <= {y_row_i, rows_q[ARRAY_WIDTH-1:1]};
    end
  end

  // Output row pointer, restarts with every captured tile
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_ptr_q <= '0;
    end else if (capture_i) begin
      row_ptr_q <= '0;
    end else if (store_i) begin
      if (last_row_o) begin
        row_ptr_q <= '0;
      end else begin
        row_ptr_q <= row_ptr_q + 1'b1;
      end
    end
  end

  assign y_bias_o   = rows_q;
  // Current row stays put until the z FIFO accepts it
  assign z_row_o    = rows_q[row_ptr_q];
  assign last_row_o = (row_ptr_q == ARRAY_WIDTH-1);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the accelerator testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project directory"
  exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_redmule \
  -f project.f --Mdir obj_dir -o tb_redmule
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_redmule > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG" || [ $sim_status -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
exit 0

// File: tb_redmule.sv
// Testbench for the accelerator with clock, reset, register access, streams, reference model and checks
`timescale 1ns/1ns

module tb_redmule
  import redmule_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int TIMEOUT    = 2000;

  logic                  clk_i, rst_n_i;
  logic                  periph_req_i, periph_we_i, periph_gnt_o, periph_rvalid_o;
  logic [REG_ADDR_W-1:0] periph_addr_i;
  logic [REG_DATA_W-1:0] periph_wdata_i, periph_rdata_o;
  logic                  x_valid_i, x_ready_o, w_valid_i, w_ready_o, y_valid_i, y_ready_o;
  x_col_t                x_data_i;
  row_t                  w_data_i, y_data_i, z_data_o;
  logic                  z_valid_o, z_ready_i, busy_o, evt_o;

  // Job operands, at most 16 steps
  x_col_t x_cols [16];
  row_t   w_rows [16];
  row_t   y_rows [ARRAY_WIDTH];
  row_t   exp_q [$];
  int     seed = 32'h7081_d1d5;
  int     err_cnt = 0;
  int     evt_cnt = 0;
  int     jobs = 0;
  bit     gap_mode = 1'b0;

  redmule_top dut0 (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  task automatic stop_run();
    err_cnt++;
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s at %0t ns", what, $time);
    stop_run();
  endtask

  task automatic check_row(input row_t got, input row_t exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_reg(input logic [REG_DATA_W-1:0] got, input logic [REG_DATA_W-1:0] exp,
                           input string what);
    if (got !== exp) begin
      $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Z = X*W + Y with every partial sum wrapped to 16 bits
  function automatic tile_t ref_tile(input int k);
    tile_t t;
    int    p;
    for (int r = 0; r < ARRAY_WIDTH; r++) begin
      for (int c = 0; c < ARRAY_HEIGHT; c++) begin
        t[r][c] = y_rows[r][c];
        for (int s = 0; s < k; s++) begin
          p = int'(x_cols[s][r]) * int'(w_rows[s][c]);
          t[r][c] = t[r][c] + elem_t'(p);
        end
      end
    end
    return t;
  endfunction

  function automatic elem_t rand_elem(input bit big);
    return big ? elem_t'($random(seed)) : elem_t'($random(seed) % 8);
  endfunction

  function automatic logic stream_ready(input int which);
    case (which)
      0:       return x_ready_o;
      1:       return w_ready_o;
      default: return y_ready_o;
    endcase
  endfunction

  task automatic drive_beat(input int which, input logic v, input int i);
    case (which)
      0: begin
        x_valid_i = v;
        x_data_i  = x_cols[i];
      end
      1: begin
        w_valid_i = v;
        w_data_i  = w_rows[i];
      end
      default: begin
        y_valid_i = v;
        y_data_i  = y_rows[i];
      end
    endcase
  endtask

  // Ready only follows the FIFO count, so it is settled at the falling edge
  task automatic feed_stream(input int which, input int n);
    int t;
    int gaps;
    for (int i = 0; i < n; i++) begin
      gaps = gap_mode ? ($random(seed) & 3) : 0;
      repeat (gaps) begin
        @(negedge clk_i);
        drive_beat(which, 1'b0, i);
      end
      @(negedge clk_i);
      drive_beat(which, 1'b1, i);
      t = 0;
      while (!stream_ready(which)) begin
        @(negedge clk_i);
        t++;
        if (t > TIMEOUT) timeout_fail("input stream ready");
      end
    end
    @(negedge clk_i);
    drive_beat(which, 1'b0, 0);
  endtask

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
    @(negedge clk_i);
    periph_req_i   = 1'b1;
    periph_we_i    = 1'b1;
    periph_addr_i  = addr;
    periph_wdata_i = data;
    #(CLK_PERIOD/4);
    check_reg(REG_DATA_W'(periph_gnt_o), 1, "write grant");
    @(negedge clk_i);
    periph_req_i = 1'b0;
    periph_we_i  = 1'b0;
  endtask

  // Response must come exactly one cycle after the grant
  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] exp);
    @(negedge clk_i);
    periph_req_i  = 1'b1;
    periph_we_i   = 1'b0;
    periph_addr_i = addr;
    #(CLK_PERIOD/4);
    check_reg(REG_DATA_W'(periph_gnt_o), 1, "read grant");
    check_reg(REG_DATA_W'(periph_rvalid_o), 0, "rvalid in grant cycle");
    @(negedge clk_i);
    periph_req_i = 1'b0;
    check_reg(REG_DATA_W'(periph_rvalid_o), 1, "rvalid after grant");
    check_reg(periph_rdata_o, exp, "read data");
    @(negedge clk_i);
    check_reg(REG_DATA_W'(periph_rvalid_o), 0, "rvalid one cycle");
  endtask

  // Every busy cycle carries a TRIGGER write, including the cycle of the last Z store
  task automatic retrigger_while_busy();
    int t;
    t = 0;
    @(negedge clk_i);
    while (busy_o) begin
      periph_req_i   = 1'b1;
      periph_we_i    = 1'b1;
      periph_addr_i  = REG_TRIGGER;
      periph_wdata_i = 1;
      @(negedge clk_i);
      t++;
      if (t > TIMEOUT) timeout_fail("busy to fall");
    end
    periph_req_i = 1'b0;
    periph_we_i  = 1'b0;
  endtask

  task automatic run_job(input int k, input bit big, input bit probe);
    tile_t exp;
    int    t;
    int    target;
    for (int s = 0; s < k; s++) begin
      for (int r = 0; r < ARRAY_WIDTH; r++) x_cols[s][r] = rand_elem(big);
      for (int c = 0; c < ARRAY_HEIGHT; c++) w_rows[s][c] = rand_elem(big);
    end
    for (int r = 0; r < ARRAY_WIDTH; r++) begin
      for (int c = 0; c < ARRAY_HEIGHT; c++) y_rows[r][c] = rand_elem(big);
    end
    exp = ref_tile(k);
    for (int r = 0; r < ARRAY_WIDTH; r++) exp_q.push_back(exp[r]);
    target = evt_cnt + 1;
    jobs++;
    reg_write(REG_K_STEPS, k);
    reg_write(REG_TRIGGER, 1);
    check_reg(REG_DATA_W'(busy_o), 1, "busy after trigger");
    // The job cannot finish before Y arrives, so busy still holds here
    if (probe) begin
      reg_read(REG_STATUS, 1);
    end
    fork
      feed_stream(0, k);
      feed_stream(1, k);
      feed_stream(2, ARRAY_WIDTH);
      if (probe) retrigger_while_busy();
    join
    t = 0;
    while (evt_cnt < target) begin
      @(negedge clk_i);
      t++;
      if (t > TIMEOUT) timeout_fail("end of job event");
    end
  endtask

  // Z consumer with optional back-pressure, compares rows in order
  always @(negedge clk_i) begin
    z_ready_i = gap_mode ? (($random(seed) & 3) != 0) : 1'b1;
    if (z_ready_i && z_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected extra Z row at %0t ns", $time);
        stop_run();
      end else begin
        check_row(z_data_o, exp_q.pop_front(), "Z row");
      end
    end
  end

  always @(negedge clk_i) begin
    if (evt_o) begin
      evt_cnt++;
      check_reg(REG_DATA_W'(busy_o), 0, "busy with event");
    end
  end

  initial begin
    int k;
    int t;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    periph_req_i = 1'b0;
    periph_we_i = 1'b0;
    periph_addr_i = '0;
    periph_wdata_i = '0;
    x_valid_i = 1'b0;
    w_valid_i = 1'b0;
    y_valid_i = 1'b0;
    x_data_i = '0;
    w_data_i = '0;
    y_data_i = '0;
    z_ready_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_reg(REG_DATA_W'({busy_o, evt_o, z_valid_o}), 0, "outputs after reset");
    reg_write(REG_K_STEPS, 32'h5a);
    reg_read(REG_K_STEPS, 32'h5a);
    reg_read(REG_STATUS, 0);
    run_job(4, 1'b0, 1'b0);
    run_job(0, 1'b1, 1'b0);
    gap_mode = 1'b1;
    run_job(6, 1'b0, 1'b0);
    run_job(3, 1'b1, 1'b0);
    run_job(5, 1'b1, 1'b1);
    // Back-to-back jobs with full range operands
    run_job(12, 1'b1, 1'b0);
    for (int j = 0; j < 4; j++) begin
      k = ($random(seed) & 32'h7fff_ffff) % 13;
      run_job(k, 1'b1, 1'b0);
    end
    t = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      t++;
      if (t > TIMEOUT) timeout_fail("remaining Z rows");
    end
    repeat (4) @(negedge clk_i);
    check_reg(evt_cnt, jobs, "event count");
    check_reg(REG_DATA_W'(busy_o), 0, "busy at end");
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
